/* files.f */
source/ooo_pkg.sv
source/rename_table.sv
source/phys_reg_file.sv
source/issue_queue.sv
source/exec_units.sv
source/reorder_buffer.sv
source/ooo_core_top.sv
bench/ooo_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f files.f --top-module ooo_core_tb -o ooo_sim || exit 1
out=$(./obj_dir/ooo_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '>>> PASS' && exit 0 || exit 1

/* bench/ooo_core_tb.sv */
module ooo_core_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ROB_DEPTH   = 8;   // same as the DUT defaults
   localparam int MUL_STAGES  = 3;
   localparam int NUM_RANDOM  = 400;
   localparam int NUM_INSTRS  = 38 + 8 + 14 + NUM_RANDOM;
   localparam int WATCHDOG_NS = NUM_INSTRS * (MUL_STAGES + ROB_DEPTH + 6) * 100;
   localparam int DRAIN_LIMIT = 20 * ROB_DEPTH;

   logic               clk;
   logic               reset;
   logic               dispatch_valid;
   ooo_pkg::opcode_t   dispatch_op;
   ooo_pkg::arch_reg_t dispatch_rd, dispatch_rs1, dispatch_rs2;
   ooo_pkg::word_t     dispatch_imm;
   logic               commit_valid;
   ooo_pkg::arch_reg_t commit_rd;
   ooo_pkg::word_t     commit_value;

   ooo_pkg::word_t     model_regs [ooo_pkg::NUM_ARCH_REGS];
   ooo_pkg::arch_reg_t exp_rd_q [$];     // expected commits, oldest first
   ooo_pkg::word_t     exp_value_q [$];
   string              exp_name_q [$];
   string              test_name;
   int                 credits, in_flight, dispatch_count, commit_count;
   int                 rd_errors, value_errors, protocol_errors;

   ooo_core_top u_ooo_core_top (
      .clk(clk), .reset(reset),
      .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
      .dispatch_rd(dispatch_rd), .dispatch_rs1(dispatch_rs1),
      .dispatch_rs2(dispatch_rs2), .dispatch_imm(dispatch_imm),
      .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // architectural result of one instruction
   function automatic ooo_pkg::word_t model_result(input ooo_pkg::opcode_t op,
         input ooo_pkg::word_t a, input ooo_pkg::word_t b, input ooo_pkg::word_t imm);
      case (op)
         ooo_pkg::op_add: return a + b;
         ooo_pkg::op_sub: return a - b;
         ooo_pkg::op_and: return a & b;
         ooo_pkg::op_or:  return a | b;
         ooo_pkg::op_xor: return a ^ b;
         ooo_pkg::op_sll: return a << b[4:0];
         ooo_pkg::op_li:  return imm;
         default:         return a * b;  // op_mul, low word
      endcase
   endfunction

   task automatic check_rd(input string name, input ooo_pkg::arch_reg_t expected,
                           input ooo_pkg::arch_reg_t actual);
      if (actual !== expected) begin
         $display("ERR %s rd expected x%0d actual x%0d", name, expected, actual);
         rd_errors++;
      end
   endtask

   task automatic check_value(input string name, input ooo_pkg::word_t expected,
                              input ooo_pkg::word_t actual);
      if (actual !== expected) begin
         $display("ERR %s value expected %08h actual %08h", name, expected, actual);
         value_errors++;
      end
   endtask

   // a commit seen at this edge hands its credit back
   task automatic next_edge();
      @(posedge clk);
      if (commit_valid) credits++;
   endtask

   task automatic send(input ooo_pkg::opcode_t op, input ooo_pkg::arch_reg_t rd,
         input ooo_pkg::arch_reg_t rs1, input ooo_pkg::arch_reg_t rs2,
         input ooo_pkg::word_t imm);
      ooo_pkg::word_t result;
      next_edge();
      while (credits == 0) begin
         dispatch_valid <= 1'b0;
         next_edge();
      end
      result         = model_result(op, model_regs[rs1], model_regs[rs2], imm);
      model_regs[rd] = result;
      exp_rd_q.push_back(rd);
      exp_value_q.push_back(result);
      exp_name_q.push_back(test_name);
      credits--;
      dispatch_count++;
      dispatch_valid <= 1'b1;
      dispatch_op    <= op;
      dispatch_rd    <= rd;
      dispatch_rs1   <= rs1;
      dispatch_rs2   <= rs2;
      dispatch_imm   <= imm;
   endtask

   // idle until every credit is back
   task automatic drain();
      int n;
      n = 0;
      while (credits != ROB_DEPTH && n < DRAIN_LIMIT) begin
         next_edge();
         dispatch_valid <= 1'b0;
         n++;
      end
      if (credits != ROB_DEPTH) begin
         $display("%s: %0d instructions left uncommitted", test_name, ROB_DEPTH - credits);
         protocol_errors++;
      end
   endtask

   // compare every commit against the model, in program order
   always @(posedge clk) begin
      if (!reset) begin
         if (dispatch_valid) in_flight++;
         if (commit_valid) begin
            in_flight--;
            commit_count++;
            if (exp_rd_q.size() == 0) begin
               $display("commit of x%0d arrived with no instruction outstanding", commit_rd);
               protocol_errors++;
            end else begin
               check_rd(exp_name_q[0], exp_rd_q.pop_front(), commit_rd);
               check_value(exp_name_q[0], exp_value_q.pop_front(), commit_value);
               void'(exp_name_q.pop_front());
            end
         end
         if (in_flight > ROB_DEPTH) begin
            $display("more instructions in flight than credits allow, dispatch without credit");
            protocol_errors++;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      void'($urandom(32'h36c));
      reset          = 1'b1;
      dispatch_valid = 1'b0;
      dispatch_op    = ooo_pkg::op_add;
      dispatch_rd    = '0;
      dispatch_rs1   = '0;
      dispatch_rs2   = '0;
      dispatch_imm   = '0;
      credits        = ROB_DEPTH;
      in_flight      = 0;
      dispatch_count = 0;
      commit_count   = 0;
      rd_errors       = 0;
      value_errors    = 0;
      protocol_errors = 0;
      for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) model_regs[i] = '0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      test_name = "idle_after_reset";
      repeat (20) begin
         next_edge();
         if (commit_valid) begin
            $display("commit_valid went high with nothing dispatched");
            protocol_errors++;
         end
      end

      test_name = "load_and_alu";
      for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
         send(ooo_pkg::op_li, 5'(i), 5'd0, 5'd0, 32'(i + 1) * 32'h9e3779b9);
      end
      send(ooo_pkg::op_add, 5'd24, 5'd1, 5'd2, '0);
      send(ooo_pkg::op_sub, 5'd25, 5'd3, 5'd4, '0);
      send(ooo_pkg::op_and, 5'd26, 5'd5, 5'd6, '0);
      send(ooo_pkg::op_or,  5'd27, 5'd7, 5'd8, '0);
      send(ooo_pkg::op_xor, 5'd28, 5'd9, 5'd10, '0);
      send(ooo_pkg::op_sll, 5'd29, 5'd11, 5'd12, '0);
      drain();

      test_name = "mul_alu_chain";
      send(ooo_pkg::op_mul, 5'd10, 5'd1, 5'd2, '0);
      send(ooo_pkg::op_add, 5'd11, 5'd10, 5'd3, '0);  // reads the multiply right away
      send(ooo_pkg::op_mul, 5'd12, 5'd11, 5'd4, '0);
      send(ooo_pkg::op_sub, 5'd13, 5'd12, 5'd10, '0);
      send(ooo_pkg::op_xor, 5'd14, 5'd13, 5'd11, '0);
      send(ooo_pkg::op_mul, 5'd15, 5'd14, 5'd14, '0);
      send(ooo_pkg::op_sll, 5'd16, 5'd15, 5'd5, '0);
      send(ooo_pkg::op_or,  5'd17, 5'd16, 5'd12, '0);
      drain();

      test_name = "rename_reuse";
      send(ooo_pkg::op_li,  5'd1, 5'd0, 5'd0, 32'h0000_1234);
      send(ooo_pkg::op_add, 5'd2, 5'd1, 5'd1, '0);
      send(ooo_pkg::op_li,  5'd1, 5'd0, 5'd0, 32'hffff_fff0);
      send(ooo_pkg::op_sub, 5'd3, 5'd1, 5'd2, '0);
      send(ooo_pkg::op_mul, 5'd2, 5'd3, 5'd1, '0);
      send(ooo_pkg::op_add, 5'd1, 5'd2, 5'd3, '0);
      send(ooo_pkg::op_xor, 5'd3, 5'd1, 5'd2, '0);
      send(ooo_pkg::op_li,  5'd2, 5'd0, 5'd0, 32'h00ff_00ff);
      send(ooo_pkg::op_and, 5'd1, 5'd1, 5'd2, '0);
      send(ooo_pkg::op_mul, 5'd20, 5'd3, 5'd3, '0);   // long op ahead of short ones
      send(ooo_pkg::op_add, 5'd21, 5'd1, 5'd2, '0);
      send(ooo_pkg::op_or,  5'd22, 5'd2, 5'd6, '0);
      send(ooo_pkg::op_sll, 5'd23, 5'd21, 5'd4, '0);
      send(ooo_pkg::op_li,  5'd3, 5'd0, 5'd0, 32'h8000_0001);
      drain();

      test_name = "random_full_rate";
      for (int n = 0; n < NUM_RANDOM; n++) begin
         send(ooo_pkg::opcode_t'(3'($urandom_range(7, 0))), 5'($urandom_range(11, 0)),
              5'($urandom_range(11, 0)), 5'($urandom_range(11, 0)), $urandom);
      end
      drain();

      repeat (2) @(posedge clk);
      if (commit_count != dispatch_count || exp_rd_q.size() != 0) begin
         $display("%0d commits seen for %0d dispatches", commit_count, dispatch_count);
         protocol_errors++;
      end
      $display("errors: rd %0d, value %0d, protocol %0d", rd_errors, value_errors,
               protocol_errors);
      if (rd_errors + value_errors + protocol_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* source/ooo_core_top.sv */
module ooo_core_top #(
   parameter int ROB_DEPTH  = 8,
   parameter int MUL_STAGES = 3
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  dispatch_valid,
   input  ooo_pkg::opcode_t      dispatch_op,
   input  ooo_pkg::arch_reg_t    dispatch_rd,
   input  ooo_pkg::arch_reg_t    dispatch_rs1,
   input  ooo_pkg::arch_reg_t    dispatch_rs2,
   input  ooo_pkg::word_t        dispatch_imm,
   output logic                  commit_valid,
   output ooo_pkg::arch_reg_t    commit_rd,
   output ooo_pkg::word_t        commit_value
);

   localparam int TAG_W = $clog2(ooo_pkg::NUM_ARCH_REGS + ROB_DEPTH);

   // rename results
   logic [TAG_W-1:0] src1_tag, src2_tag, new_tag, old_tag;
   logic             free_valid;
   logic [TAG_W-1:0] free_tag;
   // operand read at dispatch
   ooo_pkg::word_t   read1_value, read2_value;
   logic             read1_ready, read2_ready;
   // issue to execute
   logic             issue_valid;
   ooo_pkg::opcode_t issue_op;
   ooo_pkg::word_t   issue_a, issue_b;
   logic [TAG_W-1:0] issue_tag;
   // result broadcast
   logic             alu_valid, mul_valid;
   logic [TAG_W-1:0] alu_tag, mul_tag;
   ooo_pkg::word_t   alu_value, mul_value;

   rename_table #(.ROB_DEPTH(ROB_DEPTH)) u_rename_table (
      .clk(clk), .reset(reset),
      .dispatch_valid(dispatch_valid), .dispatch_rd(dispatch_rd),
      .dispatch_rs1(dispatch_rs1), .dispatch_rs2(dispatch_rs2),
      .free_valid(free_valid), .free_tag(free_tag),
      .src1_tag(src1_tag), .src2_tag(src2_tag),
      .new_tag(new_tag), .old_tag(old_tag)
   );

   phys_reg_file #(.ROB_DEPTH(ROB_DEPTH)) u_phys_reg_file (
      .clk(clk), .reset(reset),
      .alloc_valid(dispatch_valid), .alloc_tag(new_tag),
      .read1_tag(src1_tag), .read2_tag(src2_tag),
      .read1_value(read1_value), .read2_value(read2_value),
      .read1_ready(read1_ready), .read2_ready(read2_ready),
      .alu_valid(alu_valid), .mul_valid(mul_valid),
      .alu_tag(alu_tag), .mul_tag(mul_tag),
      .alu_value(alu_value), .mul_value(mul_value)
   );

   issue_queue #(.ROB_DEPTH(ROB_DEPTH)) u_issue_queue (
      .clk(clk), .reset(reset),
      .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
      .dispatch_imm(dispatch_imm),
      .src1_tag(src1_tag), .src2_tag(src2_tag), .dest_tag(new_tag),
      .src1_value(read1_value), .src2_value(read2_value),
      .src1_ready(read1_ready), .src2_ready(read2_ready),
      .alu_valid(alu_valid), .mul_valid(mul_valid),
      .alu_tag(alu_tag), .mul_tag(mul_tag),
      .alu_value(alu_value), .mul_value(mul_value),
      .issue_valid(issue_valid), .issue_op(issue_op),
      .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag)
   );

   exec_units #(.ROB_DEPTH(ROB_DEPTH), .MUL_STAGES(MUL_STAGES)) u_exec_units (
      .clk(clk), .reset(reset),
      .issue_valid(issue_valid), .issue_op(issue_op),
      .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag),
      .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value),
      .mul_valid(mul_valid), .mul_tag(mul_tag), .mul_value(mul_value)
   );

   reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
      .clk(clk), .reset(reset),
      .dispatch_valid(dispatch_valid), .dispatch_rd(dispatch_rd),
      .new_tag(new_tag), .old_tag(old_tag),
      .alu_valid(alu_valid), .mul_valid(mul_valid),
      .alu_tag(alu_tag), .mul_tag(mul_tag),
      .alu_value(alu_value), .mul_value(mul_value),
      .commit_valid(commit_valid), .commit_rd(commit_rd),
      .commit_value(commit_value),
      .free_valid(free_valid), .free_tag(free_tag)
   );

endmodule

/* source/reorder_buffer.sv */
module reorder_buffer #(
   parameter int ROB_DEPTH = 8,
   localparam int TAG_W = $clog2(ooo_pkg::NUM_ARCH_REGS + ROB_DEPTH)
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  dispatch_valid,
   input  ooo_pkg::arch_reg_t    dispatch_rd,
   input  logic [TAG_W-1:0]      new_tag,
   input  logic [TAG_W-1:0]      old_tag,
   input  logic                  alu_valid,
   input  logic                  mul_valid,
   input  logic [TAG_W-1:0]      alu_tag,
   input  logic [TAG_W-1:0]      mul_tag,
   input  ooo_pkg::word_t        alu_value,
   input  ooo_pkg::word_t        mul_value,
   output logic                  commit_valid,
   output ooo_pkg::arch_reg_t    commit_rd,
   output ooo_pkg::word_t        commit_value,
   output logic                  free_valid,
   output logic [TAG_W-1:0]      free_tag
);

   localparam int IDX_W = $clog2(ROB_DEPTH);

   logic [ROB_DEPTH-1:0] valid_q;
   logic [ROB_DEPTH-1:0] done_q;
   ooo_pkg::arch_reg_t   rd_q    [ROB_DEPTH];
   logic [TAG_W-1:0]     new_q   [ROB_DEPTH];
   logic [TAG_W-1:0]     old_q   [ROB_DEPTH];
   ooo_pkg::word_t       value_q [ROB_DEPTH];
   logic [IDX_W-1:0]     head;
   logic [IDX_W-1:0]     tail;

   // head retires the cycle after it is marked done
   assign commit_valid = valid_q[head] && done_q[head];
   assign commit_rd    = rd_q[head];
   assign commit_value = value_q[head];
   assign free_valid   = commit_valid;
   assign free_tag     = old_q[head];   // previous mapping of rd is dead now

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
         done_q  <= '0;
         head    <= '0;
         tail    <= '0;
      end else begin
         // completion, matched by destination tag
         for (int i = 0; i < ROB_DEPTH; i++) begin
            if (valid_q[i] && alu_valid && alu_tag == new_q[i]) begin
               done_q[i]  <= 1'b1;
               value_q[i] <= alu_value;
            end
            if (valid_q[i] && mul_valid && mul_tag == new_q[i]) begin
               done_q[i]  <= 1'b1;
               value_q[i] <= mul_value;
            end
         end
         if (commit_valid) begin
            valid_q[head] <= 1'b0;
            head          <= head + 1'b1;
         end
         if (dispatch_valid) begin
            valid_q[tail] <= 1'b1;
            done_q[tail]  <= 1'b0;
            rd_q[tail]    <= dispatch_rd;
            new_q[tail]   <= new_tag;
            old_q[tail]   <= old_tag;
            tail          <= tail + 1'b1;
         end
      end
   end

endmodule

/* source/exec_units.sv */
module exec_units #(
   parameter int ROB_DEPTH  = 8,
   parameter int MUL_STAGES = 3,
   localparam int TAG_W = $clog2(ooo_pkg::NUM_ARCH_REGS + ROB_DEPTH)
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  issue_valid,
   input  ooo_pkg::opcode_t      issue_op,
   input  ooo_pkg::word_t        issue_a,
   input  ooo_pkg::word_t        issue_b,
   input  logic [TAG_W-1:0]      issue_tag,
   output logic                  alu_valid,
   output logic [TAG_W-1:0]      alu_tag,
   output ooo_pkg::word_t        alu_value,
   output logic                  mul_valid,
   output logic [TAG_W-1:0]      mul_tag,
   output ooo_pkg::word_t        mul_value
);

   ooo_pkg::word_t   alu_result;
   logic             is_mul;
   logic             mul_v_q [MUL_STAGES];
   logic [TAG_W-1:0] mul_t_q [MUL_STAGES];
   ooo_pkg::word_t   mul_p_q [MUL_STAGES];

   assign is_mul = (issue_op == ooo_pkg::op_mul);

   always_comb begin
      case (issue_op)
         ooo_pkg::op_add: alu_result = issue_a + issue_b;
         ooo_pkg::op_sub: alu_result = issue_a - issue_b;
         ooo_pkg::op_and: alu_result = issue_a & issue_b;
         ooo_pkg::op_or:  alu_result = issue_a | issue_b;
         ooo_pkg::op_xor: alu_result = issue_a ^ issue_b;
         ooo_pkg::op_sll: alu_result = issue_a << issue_b[4:0];
         default:         alu_result = issue_a;  // op_li carries imm in a
      endcase
   end

   // single cycle alu
   always_ff @(posedge clk) begin
      alu_tag   <= issue_tag;
      alu_value <= alu_result;
      if (reset) alu_valid <= 1'b0;
      else alu_valid <= issue_valid && !is_mul;
   end

   // product formed on entry, later stages retime it
   always_ff @(posedge clk) begin
      mul_t_q[0] <= issue_tag;
      mul_p_q[0] <= issue_a * issue_b;
      for (int s = 1; s < MUL_STAGES; s++) begin
         mul_t_q[s] <= mul_t_q[s-1];
         mul_p_q[s] <= mul_p_q[s-1];
      end
      if (reset) begin
         for (int s = 0; s < MUL_STAGES; s++) mul_v_q[s] <= 1'b0;
      end else begin
         mul_v_q[0] <= issue_valid && is_mul;
         for (int s = 1; s < MUL_STAGES; s++) mul_v_q[s] <= mul_v_q[s-1];
      end
   end

   assign mul_valid = mul_v_q[MUL_STAGES-1];
   assign mul_tag   = mul_t_q[MUL_STAGES-1];
   assign mul_value = mul_p_q[MUL_STAGES-1];

endmodule

/* source/issue_queue.sv */
module issue_queue #(
   parameter int ROB_DEPTH = 8,
   localparam int TAG_W = $clog2(ooo_pkg::NUM_ARCH_REGS + ROB_DEPTH)
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  dispatch_valid,
   input  ooo_pkg::opcode_t      dispatch_op,
   input  ooo_pkg::word_t        dispatch_imm,
   input  logic [TAG_W-1:0]      src1_tag,
   input  logic [TAG_W-1:0]      src2_tag,
   input  logic [TAG_W-1:0]      dest_tag,
   input  ooo_pkg::word_t        src1_value,
   input  ooo_pkg::word_t        src2_value,
   input  logic                  src1_ready,
   input  logic                  src2_ready,
   input  logic                  alu_valid,
   input  logic                  mul_valid,
   input  logic [TAG_W-1:0]      alu_tag,
   input  logic [TAG_W-1:0]      mul_tag,
   input  ooo_pkg::word_t        alu_value,
   input  ooo_pkg::word_t        mul_value,
   output logic                  issue_valid,
   output ooo_pkg::opcode_t      issue_op,
   output ooo_pkg::word_t        issue_a,
   output ooo_pkg::word_t        issue_b,
   output logic [TAG_W-1:0]      issue_tag
);

   localparam int IDX_W = $clog2(ROB_DEPTH);

   logic [ROB_DEPTH-1:0] valid_q;
   ooo_pkg::opcode_t     op_q    [ROB_DEPTH];
   ooo_pkg::word_t       val_a_q [ROB_DEPTH];
   ooo_pkg::word_t       val_b_q [ROB_DEPTH];
   logic [TAG_W-1:0]     tag_a_q [ROB_DEPTH];
   logic [TAG_W-1:0]     tag_b_q [ROB_DEPTH];
   logic                 rdy_a_q [ROB_DEPTH];
   logic                 rdy_b_q [ROB_DEPTH];
   logic [TAG_W-1:0]     dest_q  [ROB_DEPTH];
   logic [IDX_W-1:0]     age_q   [ROB_DEPTH];  // number of older entries present

   logic [IDX_W-1:0] sel;
   logic [IDX_W-1:0] best_age;
   logic [IDX_W-1:0] slot;
   logic [IDX_W:0]   occupied;
   logic [IDX_W-1:0] new_age;
   logic             in_rdy_a;
   logic             in_rdy_b;
   ooo_pkg::word_t   in_val_a;
   ooo_pkg::word_t   in_val_b;

   function automatic logic bcast_hit(input logic [TAG_W-1:0] tag);
      return (alu_valid && alu_tag == tag) || (mul_valid && mul_tag == tag);
   endfunction

   // the two units never broadcast the same tag
   function automatic ooo_pkg::word_t bcast_value(input logic [TAG_W-1:0] tag);
      return (alu_valid && alu_tag == tag) ? alu_value : mul_value;
   endfunction

   // incoming operands, a broadcast in this cycle is not lost
   always_comb begin
      in_rdy_a = src1_ready || bcast_hit(src1_tag);
      in_val_a = src1_ready ? src1_value : bcast_value(src1_tag);
      in_rdy_b = src2_ready || bcast_hit(src2_tag);
      in_val_b = src2_ready ? src2_value : bcast_value(src2_tag);
      if (dispatch_op == ooo_pkg::op_li) begin
         in_rdy_a = 1'b1;
         in_val_a = dispatch_imm;
         in_rdy_b = 1'b1;
      end
   end

   // oldest ready entry, first free slot, occupancy
   always_comb begin
      issue_valid = 1'b0;
      sel         = '0;
      best_age    = '0;
      slot        = '0;
      occupied    = '0;
      for (int i = ROB_DEPTH - 1; i >= 0; i--) begin
         if (valid_q[i] && rdy_a_q[i] && rdy_b_q[i] && (!issue_valid || age_q[i] < best_age)) begin
            issue_valid = 1'b1;
            sel         = IDX_W'(i);
            best_age    = age_q[i];
         end
         if (!valid_q[i]) slot = IDX_W'(i);
         occupied = occupied + valid_q[i];
      end
      new_age = IDX_W'(occupied) - IDX_W'(issue_valid);  // youngest after this cycle's issue
   end

   assign issue_op  = op_q[sel];
   assign issue_a   = val_a_q[sel];
   assign issue_b   = val_b_q[sel];
   assign issue_tag = dest_q[sel];

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
      end else begin
         for (int i = 0; i < ROB_DEPTH; i++) begin
            // wakeup
            if (valid_q[i] && !rdy_a_q[i] && bcast_hit(tag_a_q[i])) begin
               rdy_a_q[i] <= 1'b1;
               val_a_q[i] <= bcast_value(tag_a_q[i]);
            end
            if (valid_q[i] && !rdy_b_q[i] && bcast_hit(tag_b_q[i])) begin
               rdy_b_q[i] <= 1'b1;
               val_b_q[i] <= bcast_value(tag_b_q[i]);
            end
            if (issue_valid && age_q[i] > age_q[sel]) age_q[i] <= age_q[i] - 1'b1;
         end
         if (issue_valid) valid_q[sel] <= 1'b0;
         if (dispatch_valid) begin  // credits guarantee a free slot
            valid_q[slot] <= 1'b1;
            op_q[slot]    <= dispatch_op;
            val_a_q[slot] <= in_val_a;
            val_b_q[slot] <= in_val_b;
            tag_a_q[slot] <= src1_tag;
            tag_b_q[slot] <= src2_tag;
            rdy_a_q[slot] <= in_rdy_a;
            rdy_b_q[slot] <= in_rdy_b;
            dest_q[slot]  <= dest_tag;
            age_q[slot]   <= new_age;
         end
      end
   end

endmodule

/* source/phys_reg_file.sv */
module phys_reg_file #(
   parameter int ROB_DEPTH = 8,
   localparam int TAG_W = $clog2(ooo_pkg::NUM_ARCH_REGS + ROB_DEPTH)
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  alloc_valid,
   input  logic [TAG_W-1:0]      alloc_tag,
   input  logic [TAG_W-1:0]      read1_tag,
   input  logic [TAG_W-1:0]      read2_tag,
   output ooo_pkg::word_t        read1_value,
   output ooo_pkg::word_t        read2_value,
   output logic                  read1_ready,
   output logic                  read2_ready,
   input  logic                  alu_valid,
   input  logic                  mul_valid,
   input  logic [TAG_W-1:0]      alu_tag,
   input  logic [TAG_W-1:0]      mul_tag,
   input  ooo_pkg::word_t        alu_value,
   input  ooo_pkg::word_t        mul_value
);

   localparam int NUM_PHYS = ooo_pkg::NUM_ARCH_REGS + ROB_DEPTH;

   ooo_pkg::word_t value_q [NUM_PHYS];
   logic           ready_q [NUM_PHYS];

   assign read1_value = value_q[read1_tag];
   assign read2_value = value_q[read2_tag];
   assign read1_ready = ready_q[read1_tag];
   assign read2_ready = ready_q[read2_tag];

   always_ff @(posedge clk) begin
      if (reset) begin
         // architectural state starts at zero and ready
         for (int i = 0; i < NUM_PHYS; i++) begin
            value_q[i] <= '0;
            ready_q[i] <= (i < ooo_pkg::NUM_ARCH_REGS);
         end
      end else begin
         if (alloc_valid) ready_q[alloc_tag] <= 1'b0;  // tag is free, no broadcast can hit it
         // both units may finish together
         if (alu_valid) begin
            value_q[alu_tag] <= alu_value;
            ready_q[alu_tag] <= 1'b1;
         end
         if (mul_valid) begin
            value_q[mul_tag] <= mul_value;
            ready_q[mul_tag] <= 1'b1;
         end
      end
   end

endmodule

/* source/rename_table.sv */
module rename_table #(
   parameter int ROB_DEPTH = 8,
   localparam int TAG_W = $clog2(ooo_pkg::NUM_ARCH_REGS + ROB_DEPTH)
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  dispatch_valid,
   input  ooo_pkg::arch_reg_t    dispatch_rd,
   input  ooo_pkg::arch_reg_t    dispatch_rs1,
   input  ooo_pkg::arch_reg_t    dispatch_rs2,
   input  logic                  free_valid,
   input  logic [TAG_W-1:0]      free_tag,
   output logic [TAG_W-1:0]      src1_tag,
   output logic [TAG_W-1:0]      src2_tag,
   output logic [TAG_W-1:0]      new_tag,
   output logic [TAG_W-1:0]      old_tag
);

   localparam int IDX_W = $clog2(ROB_DEPTH);

   logic [TAG_W-1:0] alias_q [ooo_pkg::NUM_ARCH_REGS];
   logic [TAG_W-1:0] free_q [ROB_DEPTH];
   logic [IDX_W-1:0] fl_head;   // next tag handed out
   logic [IDX_W-1:0] fl_tail;   // slot for the next released tag

   // lookups see the table before this cycle's rd update
   assign src1_tag = alias_q[dispatch_rs1];
   assign src2_tag = alias_q[dispatch_rs2];
   assign old_tag  = alias_q[dispatch_rd];
   assign new_tag  = free_q[fl_head];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
            alias_q[i] <= TAG_W'(i);   // identity mapping
         end
         // the spare tags start out free, so the list is full
         for (int i = 0; i < ROB_DEPTH; i++) begin
            free_q[i] <= TAG_W'(ooo_pkg::NUM_ARCH_REGS + i);
         end
         fl_head <= '0;
         fl_tail <= '0;
      end else begin
         if (dispatch_valid) begin
            alias_q[dispatch_rd] <= new_tag;
            fl_head              <= fl_head + 1'b1;
         end
         if (free_valid) begin
            free_q[fl_tail] <= free_tag;
            fl_tail         <= fl_tail + 1'b1;
         end
      end
   end

endmodule

/* source/ooo_pkg.sv */
package ooo_pkg;

   // logical register count, all 32 are ordinary registers
   localparam int NUM_ARCH_REGS = 32;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  arch_reg_t;

   // decoded operations handled by the back end
   typedef enum logic [2:0] {
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_sll,  // shift by rs2[4:0]
      op_li,   // rd = imm
      op_mul   // low 32 bits of the product
   } opcode_t;

endpackage
